/* logic/decode_defs.svh */
// Decode stage constants
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH
`default_nettype none

`define DEC_XLEN      64
`define DEC_ILEN      32
`define DEC_REG_AW    5
`define DEC_CREDITS   4
`define DEC_CREDIT_W  3

// Major opcodes
`define DEC_OP_OP       7'b0110011
`define DEC_OP_OP_32    7'b0111011
`define DEC_OP_IMM      7'b0010011
`define DEC_OP_IMM_32   7'b0011011
`define DEC_OP_LUI      7'b0110111
`define DEC_OP_AUIPC    7'b0010111
`define DEC_OP_JAL      7'b1101111
`define DEC_OP_JALR     7'b1100111
`define DEC_OP_BRANCH   7'b1100011
`define DEC_OP_LOAD     7'b0000011
`define DEC_OP_STORE    7'b0100011

// funct7 groups
`define DEC_F7_BASE     7'b0000000
`define DEC_F7_ALT      7'b0100000
`define DEC_F7_MULDIV   7'b0000001

`default_nettype wire
`endif

/* logic/decode_pkg.sv */
// Decode stage types
`include "decode_defs.svh"
`default_nettype none

package decode_pkg;

   typedef logic [`DEC_ILEN-1:0]     instr_t;
   typedef logic [`DEC_XLEN-1:0]     dword_t;
   typedef logic [`DEC_REG_AW-1:0]   reg_addr_t;
   typedef logic [`DEC_CREDIT_W-1:0] credit_t;

   typedef enum logic [1:0]
   {
      e_pipe_int,
      e_pipe_mul,
      e_pipe_long,
      e_pipe_mem
   } pipe_e;

   // Integer, M extension, then memory access size
   typedef enum logic [4:0]
   {
      e_int_op_add, e_int_op_sub, e_int_op_sll, e_int_op_slt,
      e_int_op_sltu, e_int_op_xor, e_int_op_srl, e_int_op_sra,
      e_int_op_or, e_int_op_and, e_int_op_eq, e_int_op_ne,
      e_int_op_sge, e_int_op_sgeu, e_int_op_pass_src2, e_int_op_pass_one,
      e_mul_op_mul, e_mul_op_mulh, e_mul_op_mulhsu, e_mul_op_mulhu,
      e_mul_op_div, e_mul_op_divu, e_mul_op_rem, e_mul_op_remu,
      e_mem_op_b, e_mem_op_h, e_mem_op_w, e_mem_op_d,
      e_mem_op_bu, e_mem_op_hu, e_mem_op_wu
   } fu_op_e;

   typedef enum logic
   {
      e_src1_is_rs1,
      e_src1_is_pc
   } src1_sel_e;

   typedef enum logic
   {
      e_src2_is_rs2,
      e_src2_is_imm
   } src2_sel_e;

   typedef enum logic
   {
      e_state_run,
      e_state_halt
   } stage_state_e;

endpackage

`default_nettype wire

/* logic/decode_if.sv */
// Decoded control fields
`default_nettype none

interface decode_if
   import decode_pkg::*;
();

   pipe_e     pipe;
   fu_op_e    fu_op;
   src1_sel_e src1_sel;
   src2_sel_e src2_sel;
   logic      irf_w_v;
   logic      branch_v;
   logic      jump_v;
   logic      mem_r_v;
   logic      mem_w_v;
   logic      word_v;
   logic      illegal;

   modport producer (output pipe, fu_op, src1_sel, src2_sel, irf_w_v, branch_v,
                     jump_v, mem_r_v, mem_w_v, word_v, illegal);
   modport consumer (input pipe, fu_op, src1_sel, src2_sel, irf_w_v, branch_v,
                     jump_v, mem_r_v, mem_w_v, word_v, illegal);

endinterface

`default_nettype wire

/* logic/instr_decoder.sv */
// RV64IM instruction decoder
`include "decode_defs.svh"
`default_nettype none

module instr_decoder
   import decode_pkg::*;
(
   input  instr_t     instr_i,
   decode_if.producer dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [6:0] shift_hi;
   reg_addr_t  rd;
   logic       rd_nz;
   logic       op_32;

   assign opcode = instr_i[6:0];
   assign rd     = instr_i[11:7];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];
   assign rd_nz  = (rd != '0);
   assign op_32  = (opcode == `DEC_OP_OP_32) || (opcode == `DEC_OP_IMM_32);
   // shamt is 6 bits wide on RV64, 5 bits for the word forms
   assign shift_hi = op_32 ? funct7 : {instr_i[31:26], 1'b0};

   always_comb
   begin
      dec.pipe     = e_pipe_int;
      dec.fu_op    = e_int_op_add;
      dec.src1_sel = e_src1_is_rs1;
      dec.src2_sel = e_src2_is_rs2;
      dec.irf_w_v  = 1'b0;
      dec.branch_v = 1'b0;
      dec.jump_v   = 1'b0;
      dec.mem_r_v  = 1'b0;
      dec.mem_w_v  = 1'b0;
      dec.word_v   = op_32;
      dec.illegal  = 1'b0;

      unique case (opcode)
         `DEC_OP_OP, `DEC_OP_OP_32:
         begin
            dec.irf_w_v = rd_nz;
            if (funct7 == `DEC_F7_MULDIV)
            begin
               // Plain multiply is pipelined
               dec.pipe = (funct3 == 3'b000) ? e_pipe_mul : e_pipe_long;
               unique case (funct3)
                  3'b000: dec.fu_op = e_mul_op_mul;
                  3'b001: dec.fu_op = e_mul_op_mulh;
                  3'b010: dec.fu_op = e_mul_op_mulhsu;
                  3'b011: dec.fu_op = e_mul_op_mulhu;
                  3'b100: dec.fu_op = e_mul_op_div;
                  3'b101: dec.fu_op = e_mul_op_divu;
                  3'b110: dec.fu_op = e_mul_op_rem;
                  3'b111: dec.fu_op = e_mul_op_remu;
               endcase
               // No high-half multiplies in the word forms
               dec.illegal = op_32 && (funct3 inside {3'b001, 3'b010, 3'b011});
            end
            else if (funct7 == `DEC_F7_BASE)
            begin
               unique case (funct3)
                  3'b000: dec.fu_op = e_int_op_add;
                  3'b001: dec.fu_op = e_int_op_sll;
                  3'b010: dec.fu_op = e_int_op_slt;
                  3'b011: dec.fu_op = e_int_op_sltu;
                  3'b100: dec.fu_op = e_int_op_xor;
                  3'b101: dec.fu_op = e_int_op_srl;
                  3'b110: dec.fu_op = e_int_op_or;
                  3'b111: dec.fu_op = e_int_op_and;
               endcase
               dec.illegal = op_32 && !(funct3 inside {3'b000, 3'b001, 3'b101});
            end
            else if (funct7 == `DEC_F7_ALT && funct3 == 3'b000)
               dec.fu_op = e_int_op_sub;
            else if (funct7 == `DEC_F7_ALT && funct3 == 3'b101)
               dec.fu_op = e_int_op_sra;
            else
               dec.illegal = 1'b1;
         end
         `DEC_OP_IMM, `DEC_OP_IMM_32:
         begin
            dec.irf_w_v  = rd_nz;
            dec.src2_sel = e_src2_is_imm;
            unique case (funct3)
               3'b000: dec.fu_op = e_int_op_add;
               3'b010: dec.fu_op = e_int_op_slt;
               3'b011: dec.fu_op = e_int_op_sltu;
               3'b100: dec.fu_op = e_int_op_xor;
               3'b110: dec.fu_op = e_int_op_or;
               3'b111: dec.fu_op = e_int_op_and;
               3'b001:
               begin
                  dec.fu_op   = e_int_op_sll;
                  dec.illegal = (shift_hi != `DEC_F7_BASE);
               end
               3'b101:
               begin
                  dec.fu_op   = (shift_hi == `DEC_F7_ALT) ? e_int_op_sra : e_int_op_srl;
                  dec.illegal = !(shift_hi inside {`DEC_F7_BASE, `DEC_F7_ALT});
               end
            endcase
            if (op_32 && (funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111}))
               dec.illegal = 1'b1;
         end
         `DEC_OP_LUI:
         begin
            dec.irf_w_v  = rd_nz;
            dec.fu_op    = e_int_op_pass_src2;
            dec.src2_sel = e_src2_is_imm;
         end
         `DEC_OP_AUIPC:
         begin
            dec.irf_w_v  = rd_nz;
            dec.src1_sel = e_src1_is_pc;
            dec.src2_sel = e_src2_is_imm;
         end
         `DEC_OP_JAL, `DEC_OP_JALR:
         begin
            dec.irf_w_v  = rd_nz;
            dec.branch_v = 1'b1;
            dec.jump_v   = 1'b1;
            dec.fu_op    = e_int_op_pass_one;
            dec.src1_sel = (opcode == `DEC_OP_JAL) ? e_src1_is_pc : e_src1_is_rs1;
            dec.illegal  = (opcode == `DEC_OP_JALR) && (funct3 != 3'b000);
         end
         `DEC_OP_BRANCH:
         begin
            dec.branch_v = 1'b1;
            unique case (funct3)
               3'b000:  dec.fu_op = e_int_op_eq;
               3'b001:  dec.fu_op = e_int_op_ne;
               3'b100:  dec.fu_op = e_int_op_slt;
               3'b101:  dec.fu_op = e_int_op_sge;
               3'b110:  dec.fu_op = e_int_op_sltu;
               3'b111:  dec.fu_op = e_int_op_sgeu;
               default: dec.illegal = 1'b1;
            endcase
         end
         `DEC_OP_LOAD:
         begin
            dec.pipe     = e_pipe_mem;
            dec.irf_w_v  = rd_nz;
            dec.mem_r_v  = 1'b1;
            dec.src2_sel = e_src2_is_imm;
            unique case (funct3)
               3'b000:  dec.fu_op = e_mem_op_b;
               3'b001:  dec.fu_op = e_mem_op_h;
               3'b010:  dec.fu_op = e_mem_op_w;
               3'b011:  dec.fu_op = e_mem_op_d;
               3'b100:  dec.fu_op = e_mem_op_bu;
               3'b101:  dec.fu_op = e_mem_op_hu;
               3'b110:  dec.fu_op = e_mem_op_wu;
               default: dec.illegal = 1'b1;
            endcase
         end
         `DEC_OP_STORE:
         begin
            dec.pipe     = e_pipe_mem;
            dec.mem_w_v  = 1'b1;
            dec.src2_sel = e_src2_is_imm;
            unique case (funct3)
               3'b000:  dec.fu_op = e_mem_op_b;
               3'b001:  dec.fu_op = e_mem_op_h;
               3'b010:  dec.fu_op = e_mem_op_w;
               3'b011:  dec.fu_op = e_mem_op_d;
               default: dec.illegal = 1'b1;
            endcase
         end
         default:
            dec.illegal = 1'b1;
      endcase

      // Illegal packets carry no side effects
      if (dec.illegal)
      begin
         dec.irf_w_v  = 1'b0;
         dec.branch_v = 1'b0;
         dec.jump_v   = 1'b0;
         dec.mem_r_v  = 1'b0;
         dec.mem_w_v  = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
// Immediate generator
`include "decode_defs.svh"
`default_nettype none

module imm_gen
   import decode_pkg::*;
(
   input  instr_t instr_i,
   output dword_t imm_o
);

   logic sign;

   assign sign = instr_i[31];

   always_comb
   begin
      unique case (instr_i[6:0])
         `DEC_OP_LUI, `DEC_OP_AUIPC:
            imm_o = {{(`DEC_XLEN-32){sign}}, instr_i[31:12], 12'b0};
         `DEC_OP_JAL:
            imm_o = {{(`DEC_XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                     instr_i[20], instr_i[30:21], 1'b0};
         `DEC_OP_BRANCH:
            imm_o = {{(`DEC_XLEN-13){sign}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
         `DEC_OP_STORE:
            imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
         // Shifts keep funct7 bits here, the ALU masks the shamt
         `DEC_OP_JALR, `DEC_OP_LOAD, `DEC_OP_IMM, `DEC_OP_IMM_32:
            imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:20]};
         default:
            imm_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/credit_counter.sv */
// Issue queue credit counter
`include "decode_defs.svh"
`default_nettype none

module credit_counter
   import decode_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic take_i,
   input  logic credit_i,
   output logic credit_avail_o
);

   credit_t count_q;

   // Take and return in the same cycle cancel out
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         count_q <= credit_t'(`DEC_CREDITS);
      else if (take_i && !credit_i)
         count_q <= count_q - credit_t'(1);
      else if (credit_i && !take_i)
         count_q <= count_q + credit_t'(1);
   end

   assign credit_avail_o = (count_q != '0);

   // Consumer never returns more than it was given
   count_max_a: assert property (@(posedge clk_i) disable iff (rst_i)
      count_q <= credit_t'(`DEC_CREDITS))
      else $error("credit count above queue depth");

   take_at_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
      take_i |-> credit_avail_o)
      else $error("credit taken with none left");

endmodule

`default_nettype wire

/* logic/issue_ctrl.sv */
// Run and halt control
`default_nettype none

module issue_ctrl
   import decode_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       instr_v_i,
   input  logic       credit_avail_i,
   decode_if.consumer dec,
   input  logic       redirect_i,
   output logic       instr_ready_o,
   output logic       accept_o
);

   stage_state_e state_q;
   stage_state_e state_d;

   assign instr_ready_o = (state_q == e_state_run) && credit_avail_i;
   assign accept_o      = instr_v_i && instr_ready_o;

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         e_state_run:
            if (accept_o && dec.illegal)
               state_d = e_state_halt;
         e_state_halt:
            // Front end refetches from the trap target
            if (redirect_i)
               state_d = e_state_run;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_q <= e_state_run;
      else
         state_q <= state_d;
   end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// Registered decode stage
`default_nettype none

module decode_stage
   import decode_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      instr_v_i,
   input  instr_t    instr_i,
   output logic      instr_ready_o,
   input  logic      credit_i,
   input  logic      redirect_i,
   output logic      dec_v_o,
   output pipe_e     dec_pipe_o,
   output fu_op_e    dec_fu_op_o,
   output src1_sel_e dec_src1_sel_o,
   output src2_sel_e dec_src2_sel_o,
   output logic      dec_irf_w_o,
   output logic      dec_branch_o,
   output logic      dec_jump_o,
   output logic      dec_mem_r_o,
   output logic      dec_mem_w_o,
   output logic      dec_word_o,
   output logic      dec_illegal_o,
   output dword_t    dec_imm_o
);

   decode_if dec_if ();

   dword_t imm;
   logic   accept;
   logic   credit_avail;

   instr_decoder u_instr_decoder
   (
      .instr_i (instr_i),
      .dec     (dec_if)
   );

   imm_gen u_imm_gen
   (
      .instr_i (instr_i),
      .imm_o   (imm)
   );

   credit_counter u_credit_counter
   (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .take_i         (accept),
      .credit_i       (credit_i),
      .credit_avail_o (credit_avail)
   );

   issue_ctrl u_issue_ctrl
   (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .instr_v_i      (instr_v_i),
      .credit_avail_i (credit_avail),
      .dec            (dec_if),
      .redirect_i     (redirect_i),
      .instr_ready_o  (instr_ready_o),
      .accept_o       (accept)
   );

   // Packet register
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         dec_pipe_o     <= dec_if.pipe;
         dec_fu_op_o    <= dec_if.fu_op;
         dec_src1_sel_o <= dec_if.src1_sel;
         dec_src2_sel_o <= dec_if.src2_sel;
         dec_irf_w_o    <= dec_if.irf_w_v;
         dec_branch_o   <= dec_if.branch_v;
         dec_jump_o     <= dec_if.jump_v;
         dec_mem_r_o    <= dec_if.mem_r_v;
         dec_mem_w_o    <= dec_if.mem_w_v;
         dec_word_o     <= dec_if.word_v;
         dec_illegal_o  <= dec_if.illegal;
         dec_imm_o      <= imm;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         dec_v_o <= 1'b0;
      else
         dec_v_o <= accept;
   end

endmodule

`default_nettype wire

/* bench/decode_vectors.svh */
// Decode test vectors
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

   // instr, pipe, fu_op, sel {src1, src2}, imm
   // flags {irf_w, branch, jump, mem_r, mem_w, word, illegal}
   typedef struct {
      instr_t     instr;
      pipe_e      pipe;
      fu_op_e     fu_op;
      logic [1:0] sel;
      logic [6:0] flags;
      dword_t     imm;
   } vector_t;

   vector_t vectors [$];

   function automatic void add_row(input instr_t instr, input pipe_e pipe,
                                   input fu_op_e fu_op, input logic [1:0] sel,
                                   input logic [6:0] flags, input dword_t imm);
      vectors.push_back('{instr, pipe, fu_op, sel, flags, imm});
   endfunction

   task automatic load_vectors();
      // Register ALU and M extension
      add_row(32'h002081b3, e_pipe_int, e_int_op_add, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h407302b3, e_pipe_int, e_int_op_sub, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h403150b3, e_pipe_int, e_int_op_sra, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h02c58533, e_pipe_mul, e_mul_op_mul, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h02c5d533, e_pipe_long, e_mul_op_divu, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h02c5b533, e_pipe_long, e_mul_op_mulhu, 2'b00, 7'b1000000, 64'h0);
      add_row(32'h02c5e53b, e_pipe_long, e_mul_op_rem, 2'b00, 7'b1000010, 64'h0);
      // addw to x0
      add_row(32'h0020803b, e_pipe_int, e_int_op_add, 2'b00, 7'b0000010, 64'h0);
      add_row(32'hfff10093, e_pipe_int, e_int_op_add, 2'b01, 7'b1000000, '1);
      add_row(32'h02121193, e_pipe_int, e_int_op_sll, 2'b01, 7'b1000000, 64'h21);
      // ecall is outside the kept groups
      add_row(32'h00000073, e_pipe_int, e_int_op_add, 2'b00, 7'b0000001, 64'h0);
      add_row(32'h40735293, e_pipe_int, e_int_op_sra, 2'b01, 7'b1000000, 64'h407);
      add_row(32'h0054039b, e_pipe_int, e_int_op_add, 2'b01, 7'b1000010, 64'h5);
      add_row(32'h800002b7, e_pipe_int, e_int_op_pass_src2, 2'b01, 7'b1000000,
              64'hffffffff80000000);
      add_row(32'h12345317, e_pipe_int, e_int_op_add, 2'b11, 7'b1000000, 64'h12345000);
      // Jumps
      add_row(32'hffdff0ef, e_pipe_int, e_int_op_pass_one, 2'b10, 7'b1110000,
              64'hfffffffffffffffc);
      add_row(32'h0010006f, e_pipe_int, e_int_op_pass_one, 2'b10, 7'b0110000, 64'h800);
      add_row(32'h010280e7, e_pipe_int, e_int_op_pass_one, 2'b00, 7'b1110000, 64'h10);
      add_row(32'hfe208ce3, e_pipe_int, e_int_op_eq, 2'b00, 7'b0100000,
              64'hfffffffffffffff8);
      add_row(32'h0041f863, e_pipe_int, e_int_op_sgeu, 2'b00, 7'b0100000, 64'h10);
      // mulhw has no RV64 encoding
      add_row(32'h02c5953b, e_pipe_int, e_int_op_add, 2'b00, 7'b0000001, 64'h0);
      // Loads and stores
      add_row(32'hff013403, e_pipe_mem, e_mem_op_d, 2'b01, 7'b1001000,
              64'hfffffffffffffff0);
      add_row(32'h0070c483, e_pipe_mem, e_mem_op_bu, 2'b01, 7'b1001000, 64'h7);
      add_row(32'h00512623, e_pipe_mem, e_mem_op_w, 2'b01, 7'b0000100, 64'hc);
      add_row(32'hfe60bc23, e_pipe_mem, e_mem_op_d, 2'b01, 7'b0000100,
              64'hfffffffffffffff8);
      add_row(32'h0062e233, e_pipe_int, e_int_op_or, 2'b00, 7'b1000000, 64'h0);
   endtask

`endif

/* bench/tb_decode_stage.sv */
// Decode stage testbench
`include "decode_defs.svh"
`default_nettype none

module tb_decode_stage
   import decode_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_HALF     = 50;
   localparam int          RESET_CYCLES = 5;
   localparam logic [31:0] LFSR_SEED    = 32'h65f51abd;

   logic      clk_i = 1'b0;
   logic      rst_i;
   logic      instr_v_i;
   instr_t    instr_i;
   logic      instr_ready_o;
   logic      credit_i;
   logic      redirect_i;
   logic      dec_v_o;
   pipe_e     dec_pipe_o;
   fu_op_e    dec_fu_op_o;
   src1_sel_e dec_src1_sel_o;
   src2_sel_e dec_src2_sel_o;
   logic      dec_irf_w_o;
   logic      dec_branch_o;
   logic      dec_jump_o;
   logic      dec_mem_r_o;
   logic      dec_mem_w_o;
   logic      dec_word_o;
   logic      dec_illegal_o;
   dword_t    dec_imm_o;

   `include "decode_vectors.svh"

   logic [31:0] lfsr_state;
   int          timeout_cycles = 0;
   int          row_idx;
   int          credits_exp;
   int          owed;
   logic        halt_exp;
   int          halt_wait;
   logic        expect_v;
   vector_t     expected_q [$];

   decode_stage u_decode_stage
   (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .instr_v_i      (instr_v_i),
      .instr_i        (instr_i),
      .instr_ready_o  (instr_ready_o),
      .credit_i       (credit_i),
      .redirect_i     (redirect_i),
      .dec_v_o        (dec_v_o),
      .dec_pipe_o     (dec_pipe_o),
      .dec_fu_op_o    (dec_fu_op_o),
      .dec_src1_sel_o (dec_src1_sel_o),
      .dec_src2_sel_o (dec_src2_sel_o),
      .dec_irf_w_o    (dec_irf_w_o),
      .dec_branch_o   (dec_branch_o),
      .dec_jump_o     (dec_jump_o),
      .dec_mem_r_o    (dec_mem_r_o),
      .dec_mem_w_o    (dec_mem_w_o),
      .dec_word_o     (dec_word_o),
      .dec_illegal_o  (dec_illegal_o),
      .dec_imm_o      (dec_imm_o)
   );

   always #CLK_HALF clk_i = ~clk_i;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bit(output logic b);
      lfsr_state = lfsr_step(lfsr_state);
      b = lfsr_state[0];
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("ERROR %s expected %h got %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic fail_run(input string why);
      $display("Simulation failed");
      $fatal(1, "%s", why);
   endtask

   task automatic check_packet(input vector_t row);
      check_value("dec_illegal_o", 64'(row.flags[0]), 64'(dec_illegal_o));
      check_value("dec_irf_w_o", 64'(row.flags[6]), 64'(dec_irf_w_o));
      check_value("dec_branch_o", 64'(row.flags[5]), 64'(dec_branch_o));
      check_value("dec_jump_o", 64'(row.flags[4]), 64'(dec_jump_o));
      check_value("dec_mem_r_o", 64'(row.flags[3]), 64'(dec_mem_r_o));
      check_value("dec_mem_w_o", 64'(row.flags[2]), 64'(dec_mem_w_o));
      // Op fields of an illegal packet carry no meaning
      if (!row.flags[0])
      begin
         check_value("dec_pipe_o", 64'(row.pipe), 64'(dec_pipe_o));
         check_value("dec_fu_op_o", 64'(row.fu_op), 64'(dec_fu_op_o));
         check_value("dec_src1_sel_o", 64'(row.sel[1]), 64'(dec_src1_sel_o));
         check_value("dec_src2_sel_o", 64'(row.sel[0]), 64'(dec_src2_sel_o));
         check_value("dec_word_o", 64'(row.flags[1]), 64'(dec_word_o));
         check_value("dec_imm_o", row.imm, dec_imm_o);
      end
   endtask

   task automatic run_cycle();
      vector_t row;
      logic    ready_exp;
      logic    bit_a;
      logic    bit_b;
      logic    offer;

      @(negedge clk_i);
      check_value("dec_v_o", 64'(expect_v), 64'(dec_v_o));
      if (dec_v_o)
      begin
         if (expected_q.size() == 0)
            fail_run("Packet seen with no accepted instruction pending");
         else
         begin
            row = expected_q.pop_front();
            check_packet(row);
            owed++;
         end
      end
      if (owed > `DEC_CREDITS)
         fail_run("More packets in flight than issue queue entries");
      ready_exp = !halt_exp && (credits_exp > 0);
      check_value("instr_ready_o", 64'(ready_exp), 64'(instr_ready_o));

      draw_bit(bit_a);
      draw_bit(bit_b);
      credit_i = (owed > 0) && bit_a && bit_b;
      if (credit_i)
      begin
         owed--;
         credits_exp++;
      end

      // Trap held for a few cycles before the front end redirects
      redirect_i = 1'b0;
      if (halt_exp)
      begin
         if (halt_wait == 0)
         begin
            redirect_i = 1'b1;
            halt_exp   = 1'b0;
         end
         else
            halt_wait--;
      end

      offer = 1'b0;
      if (row_idx < vectors.size())
      begin
         draw_bit(bit_a);
         draw_bit(bit_b);
         offer   = bit_a || bit_b;
         instr_i = vectors[row_idx].instr;
      end
      instr_v_i = offer;
      expect_v  = offer && ready_exp;
      if (expect_v)
      begin
         expected_q.push_back(vectors[row_idx]);
         credits_exp--;
         if (vectors[row_idx].flags[0])
         begin
            draw_bit(bit_a);
            draw_bit(bit_b);
            halt_exp  = 1'b1;
            halt_wait = 1 + int'({bit_a, bit_b});
         end
         row_idx++;
      end
   endtask

   initial
   begin
      rst_i       = 1'b1;
      instr_v_i   = 1'b0;
      instr_i     = '0;
      credit_i    = 1'b0;
      redirect_i  = 1'b0;
      lfsr_state  = LFSR_SEED;
      row_idx     = 0;
      credits_exp = `DEC_CREDITS;
      owed        = 0;
      halt_exp    = 1'b0;
      halt_wait   = 0;
      expect_v    = 1'b0;
      load_vectors();
      timeout_cycles = 20 * vectors.size() + 100;

      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      check_value("dec_v_o", 64'(1'b0), 64'(dec_v_o));
      check_value("instr_ready_o", 64'(1'b1), 64'(instr_ready_o));

      while (row_idx < vectors.size() || expected_q.size() > 0 || owed > 0)
         run_cycle();
      // Every credit is back, so intake must be open
      run_cycle();

      $display("Simulation completed successfully");
      $finish;
   end

   initial
   begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk_i);
      $display("Simulation failed");
      $fatal(1, "Watchdog expired after %0d cycles", timeout_cycles);
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+bench
logic/decode_pkg.sv
logic/decode_if.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/credit_counter.sv
logic/issue_ctrl.sv
logic/decode_stage.sv
bench/tb_decode_stage.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
HEADERS   ?= logic/decode_defs.svh bench/decode_vectors.svh

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
